//--- cpu.f
+incdir+rtl
rtl/cpu_pkg.sv
rtl/control.sv
rtl/fetch.sv
rtl/regfile.sv
rtl/alu.sv
rtl/cpu.sv
verification/cpu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f cpu.f --top-module cpu_tb -o cpu_tb_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/cpu_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
	exit 1
fi
if ! grep -q "Simulation finished: PASS" "$LOG"; then
	echo "Simulation ended without a result line"
	exit 1
fi
exit 0

//--- verification/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module cpu_tb import cpu_pkg::*; ();

	localparam int    PROG_LEN       = 200;
	localparam int    END_INDEX      = PROG_LEN;
	localparam word_t END_PC         = 32'(END_INDEX * 4);
	localparam int    TIMEOUT_CYCLES = 10 + 3 * PROG_LEN + 50;

	logic      clk;
	logic      arst_n;
	word_t     imem_addr;
	word_t     imem_data;
	word_t     cpu_addr;
	word_t     cpu_write_data;
	logic      dev_write_enable;
	logic      dev_read_enable;
	word_t     cpu_read_result;
	wb_trace_t wb_trace;

	word_t imem [0:255];
	word_t dmem [0:15];
	word_t model_mem [0:15];
	word_t exp_wdest [$];
	word_t exp_wdata [$];
	word_t exp_saddr [$];
	word_t exp_sdata [$];
	word_t exp_laddr [$];
	word_t lfsr_state;
	int    errors = 0;
	int    widx = 0;
	int    sidx = 0;
	int    lidx = 0;
	int    cycles;

	cpu u_cpu (
		.clk              (clk),
		.arst_n           (arst_n),
		.imem_addr        (imem_addr),
		.imem_data        (imem_data),
		.cpu_addr         (cpu_addr),
		.cpu_write_data   (cpu_write_data),
		.dev_write_enable (dev_write_enable),
		.dev_read_enable  (dev_read_enable),
		.cpu_read_result  (cpu_read_result),
		.wb_trace         (wb_trace)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic word_t fill_word(int k);
		return 32'hd000_0000 + 32'(k) * 32'h0013_0507;
	endfunction

	// Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit handed out.
	function automatic word_t take_bits(int n);
		word_t bits;
		logic  fb;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			bits = {bits[30:0], fb};
		end
		return bits;
	endfunction

	function automatic word_t enc_r(logic [5:0] fn, reg_addr_t rs, reg_addr_t rt, reg_addr_t rd);
		return {`OP_SPECIAL, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic word_t enc_i(logic [5:0] op, reg_addr_t rs, reg_addr_t rt,
		logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// Both memories answer in the same cycle.
	assign imem_data       = imem[imem_addr[9:2]];
	assign cpu_read_result = dmem[cpu_addr[5:2]];

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int k = 0; k < 16; k++) begin
				dmem[k] <= fill_word(k);
			end
		end else if (dev_write_enable) begin
			dmem[cpu_addr[5:2]] <= cpu_write_data;
		end
	end

	task automatic gen_program();
		word_t       kind;
		reg_addr_t   rs;
		reg_addr_t   rt;
		reg_addr_t   rd;
		logic [15:0] imm;
		logic [5:0]  fn;
		logic        prev_beq;
		prev_beq = 1'b0;
		for (int i = 0; i < 256; i++) begin
			imem[i] = '0;
		end
		for (int i = 0; i < PROG_LEN; i++) begin
			kind = take_bits(4);
			rs   = 5'(take_bits(3));
			rt   = 5'(take_bits(3));
			rd   = 5'(take_bits(3));
			imm  = 16'(take_bits(16));
			// Branch targets never pass the final jump, and a delay slot never holds a branch.
			if (kind >= 13 && !prev_beq && i < PROG_LEN - 3) begin
				if (take_bits(1) == 32'd1)
					rt = rs;
				imem[i] = enc_i(`OP_BEQ, rs, rt, 16'(take_bits(2) % 3 + 1));
			end else if (kind >= 11) begin
				imem[i] = enc_i(`OP_SW, 5'd0, rt, {10'd0, imm[3:0], 2'b00});
			end else if (kind >= 9) begin
				imem[i] = enc_i(`OP_LW, 5'd0, rt, {10'd0, imm[3:0], 2'b00});
			end else if (kind == 8) begin
				imem[i] = enc_i(`OP_LUI, 5'd0, rt, imm);
			end else if (kind >= 6) begin
				imem[i] = enc_i(`OP_ORI, rs, rt, imm);
			end else begin
				case (take_bits(3) % 5)
					0:       fn = `FN_ADDU;
					1:       fn = `FN_SUBU;
					2:       fn = `FN_AND;
					3:       fn = `FN_OR;
					default: fn = `FN_SLT;
				endcase
				imem[i] = enc_r(fn, rs, rt, rd);
			end
			prev_beq = imem[i][31:26] == `OP_BEQ;
		end
		imem[END_INDEX]     = {`OP_J, 26'(END_INDEX)};
		imem[END_INDEX + 1] = '0;
	endtask

	// In-order reference with one delay slot after every branch and jump.
	task automatic run_model();
		word_t     regs [0:31];
		word_t     ins;
		word_t     a;
		word_t     b;
		word_t     res;
		word_t     addr;
		reg_addr_t dest;
		int        pc;
		int        npc;
		int        next_npc;
		for (int k = 0; k < 32; k++) begin
			regs[k] = '0;
		end
		for (int k = 0; k < 16; k++) begin
			model_mem[k] = fill_word(k);
		end
		pc  = 0;
		npc = 1;
		while (pc != END_INDEX) begin
			ins      = imem[pc];
			a        = regs[ins[25:21]];
			b        = regs[ins[20:16]];
			addr     = a + {{16{ins[15]}}, ins[15:0]};
			res      = '0;
			dest     = '0;
			next_npc = npc + 1;
			case (ins[31:26])
				`OP_SPECIAL: begin
					dest = ins[15:11];
					case (ins[5:0])
						`FN_ADDU: res = a + b;
						`FN_SUBU: res = a - b;
						`FN_AND:  res = a & b;
						`FN_OR:   res = a | b;
						`FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default:  dest = '0;
					endcase
				end
				`OP_ORI: begin
					dest = ins[20:16];
					res  = a | {16'h0000, ins[15:0]};
				end
				`OP_LUI: begin
					dest = ins[20:16];
					res  = {ins[15:0], 16'h0000};
				end
				`OP_LW: begin
					dest = ins[20:16];
					res  = model_mem[addr[5:2]];
					exp_laddr.push_back(addr);
				end
				`OP_SW: begin
					model_mem[addr[5:2]] = b;
					exp_saddr.push_back(addr);
					exp_sdata.push_back(b);
				end
				`OP_BEQ: begin
					if (a == b)
						next_npc = npc + int'($signed(ins[15:0]));
				end
				default: ;
			endcase
			if (dest != '0) begin
				regs[dest] = res;
				exp_wdest.push_back(32'(dest));
				exp_wdata.push_back(res);
			end
			pc  = npc;
			npc = next_npc;
		end
	endtask

	task automatic check(input string name, input word_t expected, input word_t actual);
		if (expected !== actual) begin
			errors++;
			$display("error %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic print_summary();
		$display("errors %0d, writes %0d of %0d, stores %0d of %0d, loads %0d of %0d",
			errors, widx, exp_wdest.size(), sidx, exp_saddr.size(), lidx, exp_laddr.size());
	endtask

	// The jump has left decode once its address is fetched again after its delay slot.
	task automatic wait_for_final_jump();
		logic slot_seen;
		logic done;
		slot_seen = 1'b0;
		done      = 1'b0;
		while (!done) begin
			@(negedge clk);
			if (imem_addr == END_PC + 32'd4)
				slot_seen = 1'b1;
			else if (slot_seen && imem_addr == END_PC)
				done = 1'b1;
		end
	endtask

	always @(negedge clk) begin
		if (arst_n && wb_trace.valid) begin
			if (wb_trace.dest == '0) begin
				errors++;
				$display("retire port pulsed for register zero with data %h", wb_trace.data);
			end else if (widx >= exp_wdest.size()) begin
				errors++;
				$display("unexpected write of %h to register %0d", wb_trace.data, wb_trace.dest);
			end else begin
				check($sformatf("retire %0d dest", widx), exp_wdest[widx], 32'(wb_trace.dest));
				check($sformatf("retire %0d data", widx), exp_wdata[widx], wb_trace.data);
				widx++;
			end
		end
		if (arst_n && dev_write_enable) begin
			if (sidx >= exp_saddr.size()) begin
				errors++;
				$display("unexpected store of %h to address %h", cpu_write_data, cpu_addr);
			end else begin
				check($sformatf("store %0d address", sidx), exp_saddr[sidx], cpu_addr);
				check($sformatf("store %0d data", sidx), exp_sdata[sidx], cpu_write_data);
				sidx++;
			end
		end
		if (arst_n && dev_read_enable) begin
			if (lidx >= exp_laddr.size()) begin
				errors++;
				$display("unexpected load from address %h", cpu_addr);
			end else begin
				check($sformatf("load %0d address", lidx), exp_laddr[lidx], cpu_addr);
				lidx++;
			end
		end
	end

	initial begin
		for (cycles = 0; cycles < TIMEOUT_CYCLES; cycles++)
			@(posedge clk);
		errors++;
		$display("hang: the program did not reach its final jump in %0d cycles", TIMEOUT_CYCLES);
		print_summary();
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		arst_n <= 1'b0;
		lfsr_state = 32'd92425;
		gen_program();
		run_model();
		repeat (10) @(posedge clk);
		check("reset write enable", 32'd0, 32'(dev_write_enable));
		check("reset read enable", 32'd0, 32'(dev_read_enable));
		check("reset retire valid", 32'd0, 32'(wb_trace.valid));
		arst_n <= 1'b1;
		wait_for_final_jump();
		repeat (4) @(posedge clk);
		check("retire count", 32'(exp_wdest.size()), 32'(widx));
		check("store count", 32'(exp_saddr.size()), 32'(sidx));
		check("load count", 32'(exp_laddr.size()), 32'(lidx));
		for (int k = 0; k < 16; k++) begin
			check($sformatf("data word %0d", k), model_mem[k], dmem[k]);
		end
		print_summary();
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- rtl/cpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module cpu import cpu_pkg::*; (
	input  logic      clk,
	input  logic      arst_n,
	output word_t     imem_addr,
	input  word_t     imem_data,
	output word_t     cpu_addr,
	output word_t     cpu_write_data,
	output logic      dev_write_enable,
	output logic      dev_read_enable,
	input  word_t     cpu_read_result,
	output wb_trace_t wb_trace
);

	if_id_t    if_id;
	id_ex_t    id_ex;
	ex_mem_t   ex_mem;
	mem_wb_t   mem_wb;

	logic      pc_enable;
	logic      if_id_enable;
	logic      id_ex_flush;
	logic [1:0] npc_mode;
	ex_ctrl_t  ex_ctrl;
	mem_ctrl_t mem_ctrl;
	wb_ctrl_t  wb_ctrl;
	fwd_ctrl_t fwd;

	word_t     d_rs_raw;
	word_t     d_rt_raw;
	word_t     d_rs_val;
	word_t     d_rt_val;
	logic      d_equal;
	word_t     e_rs_val;
	word_t     e_rt_val;
	word_t     e_alu_y;
	word_t     w_data;

	function automatic word_t fwd_mux(fwd_sel_t sel, word_t orig, word_t mem_val,
		word_t wb_val);
		case (sel)
			fwd_mem: return mem_val;
			fwd_wb:  return wb_val;
			default: return orig;
		endcase
	endfunction

	control u_control (
		.d_instr      (if_id.instr),
		.e_instr      (id_ex.instr),
		.m_instr      (ex_mem.instr),
		.w_instr      (mem_wb.instr),
		.pc_enable    (pc_enable),
		.if_id_enable (if_id_enable),
		.id_ex_flush  (id_ex_flush),
		.npc_mode     (npc_mode),
		.ex_ctrl      (ex_ctrl),
		.mem_ctrl     (mem_ctrl),
		.wb_ctrl      (wb_ctrl),
		.fwd          (fwd)
	);

	fetch u_fetch (
		.clk       (clk),
		.arst_n    (arst_n),
		.pc_enable (pc_enable),
		.npc_mode  (npc_mode),
		.d_pc      (if_id.pc),
		.d_instr   (if_id.instr),
		.d_equal   (d_equal),
		.pc        (imem_addr)
	);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			if_id <= '0;
		end else if (if_id_enable) begin
			if_id <= '{pc: imem_addr, instr: imem_data};
		end
	end

	regfile u_regfile (
		.clk    (clk),
		.arst_n (arst_n),
		.raddr1 (if_id.instr[25:21]),
		.raddr2 (if_id.instr[20:16]),
		.waddr  (wb_ctrl.dest),
		.wdata  (w_data),
		.we     (wb_ctrl.reg_write),
		.rdata1 (d_rs_raw),
		.rdata2 (d_rt_raw)
	);

	assign d_rs_val = fwd_mux(fwd.d1, d_rs_raw, ex_mem.alu_result, w_data);
	assign d_rt_val = fwd_mux(fwd.d2, d_rt_raw, ex_mem.alu_result, w_data);
	assign d_equal  = d_rs_val == d_rt_val;

	// A stall leaves decode in place and sends a zero instruction down as a bubble.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			id_ex <= '0;
		end else if (id_ex_flush) begin
			id_ex <= '0;
		end else begin
			id_ex <= '{pc: if_id.pc, instr: if_id.instr, rs_val: d_rs_val, rt_val: d_rt_val};
		end
	end

	assign e_rs_val = fwd_mux(fwd.e1, id_ex.rs_val, ex_mem.alu_result, w_data);
	assign e_rt_val = fwd_mux(fwd.e2, id_ex.rt_val, ex_mem.alu_result, w_data);

	alu u_alu (
		.ctrl (ex_ctrl),
		.a    (e_rs_val),
		.b    (e_rt_val),
		.imm  (id_ex.instr[15:0]),
		.y    (e_alu_y)
	);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_mem <= '0;
		end else begin
			ex_mem <= '{instr: id_ex.instr, alu_result: e_alu_y, store_data: e_rt_val};
		end
	end

	assign cpu_addr         = ex_mem.alu_result;
	assign cpu_write_data   = fwd_mux(fwd.m, ex_mem.store_data, ex_mem.alu_result, w_data);
	assign dev_write_enable = mem_ctrl.mem_write;
	assign dev_read_enable  = mem_ctrl.mem_read;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mem_wb <= '0;
		end else begin
			mem_wb <= '{instr: ex_mem.instr, alu_result: ex_mem.alu_result,
				load_data: cpu_read_result};
		end
	end

	assign w_data   = (wb_ctrl.wb_sel == wb_mem) ? mem_wb.load_data : mem_wb.alu_result;
	assign wb_trace = '{valid: wb_ctrl.reg_write, dest: wb_ctrl.dest, data: w_data};

	// The delay slot always follows a branch or jump directly, even across stalls.
	a_delay_slot: assert property (@(posedge clk) disable iff (!arst_n)
		(id_ex.instr[31:26] == `OP_BEQ || id_ex.instr[31:26] == `OP_J) |->
		if_id.pc == id_ex.pc + 32'd4)
		else $error("cpu: delay slot of %h is not in decode", id_ex.pc);

	// A jump reads no registers, so it never stalls and reaches execute one cycle later.
	a_jump_leaves_decode: assert property (@(posedge clk) disable iff (!arst_n)
		if_id.instr[31:26] == `OP_J |=> id_ex.instr == $past(if_id.instr))
		else $error("cpu: jump at %h stalled in decode", if_id.pc);

endmodule

`default_nettype wire

//--- rtl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import cpu_pkg::*; (
	input  ex_ctrl_t    ctrl,
	input  word_t       a,
	input  word_t       b,
	input  logic [15:0] imm,
	output word_t       y
);

	word_t imm_ext;
	word_t op2;

	// ori zero-extends. Loads and stores sign-extend their offset.
	assign imm_ext = ctrl.zero_ext ? {16'h0000, imm} : {{16{imm[15]}}, imm};
	assign op2     = ctrl.use_imm ? imm_ext : b;

	always_comb begin
		case (ctrl.alu_op)
			alu_add: y = a + op2;
			alu_sub: y = a - op2;
			alu_and: y = a & op2;
			alu_or:  y = a | op2;
			alu_slt: y = {31'b0, $signed(a) < $signed(op2)};
			alu_lui: y = {imm, 16'h0000};
			default: y = a + op2;
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module regfile import cpu_pkg::*; (
	input  logic      clk,
	input  logic      arst_n,
	input  reg_addr_t raddr1,
	input  reg_addr_t raddr2,
	input  reg_addr_t waddr,
	input  word_t     wdata,
	input  logic      we,
	output word_t     rdata1,
	output word_t     rdata2
);

	word_t regs [`CPU_NUM_REGS];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `CPU_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// Register zero reads as zero. A write in progress is visible to decode in the same cycle.
	assign rdata1 = (raddr1 == '0) ? '0 :
		(we && raddr1 == waddr) ? wdata : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 :
		(we && raddr2 == waddr) ? wdata : regs[raddr2];

	// Control suppresses every write to register zero before it reaches write-back.
	a_no_zero_write: assert property (@(posedge clk) disable iff (!arst_n)
		!(we && waddr == '0))
		else $error("regfile: write enable with register zero");

endmodule

`default_nettype wire

//--- rtl/fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module fetch import cpu_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       pc_enable,
	input  logic [1:0] npc_mode,
	input  word_t      d_pc,
	input  word_t      d_instr,
	input  logic       d_equal,
	output word_t      pc
);

	word_t seq_pc;
	word_t slot_pc;
	word_t branch_pc;
	word_t jump_pc;
	word_t next_pc;

	assign seq_pc = pc + 32'd4;

	// Targets are relative to the delay slot, which sits right behind the instruction in decode.
	assign slot_pc   = d_pc + 32'd4;
	assign branch_pc = slot_pc + {{14{d_instr[15]}}, d_instr[15:0], 2'b00};
	assign jump_pc   = {slot_pc[31:28], d_instr[25:0], 2'b00};

	always_comb begin
		case (npc_mode)
			`NPC_BRANCH: next_pc = d_equal ? branch_pc : seq_pc;
			`NPC_JUMP:   next_pc = jump_pc;
			default:     next_pc = seq_pc;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= `CPU_RESET_PC;
		end else if (pc_enable) begin
			pc <= next_pc;
		end
	end

	a_pc_aligned: assert property (@(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00)
		else $error("fetch: misaligned pc %h", pc);

endmodule

`default_nettype wire

//--- rtl/control.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module control import cpu_pkg::*; (
	input  word_t      d_instr,
	input  word_t      e_instr,
	input  word_t      m_instr,
	input  word_t      w_instr,
	output logic       pc_enable,
	output logic       if_id_enable,
	output logic       id_ex_flush,
	output logic [1:0] npc_mode,
	output ex_ctrl_t   ex_ctrl,
	output mem_ctrl_t  mem_ctrl,
	output wb_ctrl_t   wb_ctrl,
	output fwd_ctrl_t  fwd
);

	function automatic logic is_rtype(word_t instr);
		logic [5:0] fn;
		fn = instr[5:0];
		return instr[31:26] == `OP_SPECIAL &&
			(fn == `FN_ADDU || fn == `FN_SUBU || fn == `FN_AND ||
			fn == `FN_OR || fn == `FN_SLT);
	endfunction

	// Zero when the instruction writes no register.
	function automatic reg_addr_t dest_of(word_t instr);
		if (is_rtype(instr))
			return instr[15:11];
		case (instr[31:26])
			`OP_ORI, `OP_LUI, `OP_LW: return instr[20:16];
			default: return '0;
		endcase
	endfunction

	function automatic logic reads_rs(word_t instr);
		case (instr[31:26])
			`OP_ORI, `OP_LW, `OP_SW, `OP_BEQ: return 1'b1;
			default: return is_rtype(instr);
		endcase
	endfunction

	function automatic logic reads_rt(word_t instr);
		case (instr[31:26])
			`OP_SW, `OP_BEQ: return 1'b1;
			default: return is_rtype(instr);
		endcase
	endfunction

	// The younger match wins, so memory is checked before write-back.
	function automatic fwd_sel_t pick(reg_addr_t src, reg_addr_t mem_dest, reg_addr_t wb_dest);
		if (src != '0 && src == mem_dest)
			return fwd_mem;
		if (src != '0 && src == wb_dest)
			return fwd_wb;
		return fwd_orig;
	endfunction

	reg_addr_t d_rs;
	reg_addr_t d_rt;
	reg_addr_t e_rs;
	reg_addr_t e_rt;
	reg_addr_t m_rt;
	reg_addr_t e_dest;
	reg_addr_t m_dest;
	reg_addr_t m_fwd_dest;
	reg_addr_t w_dest;
	logic      e_load;
	logic      m_load;
	logic      d_beq;
	logic      load_use;
	logic      branch_stall;
	logic      stall;

	assign d_rs = d_instr[25:21];
	assign d_rt = d_instr[20:16];
	assign e_rs = e_instr[25:21];
	assign e_rt = e_instr[20:16];
	assign m_rt = m_instr[20:16];

	assign e_dest = dest_of(e_instr);
	assign m_dest = dest_of(m_instr);
	assign w_dest = dest_of(w_instr);
	assign e_load = e_instr[31:26] == `OP_LW;
	assign m_load = m_instr[31:26] == `OP_LW;
	assign d_beq  = d_instr[31:26] == `OP_BEQ;

	// A load in memory has only its address in the ALU result, so it never forwards from there.
	assign m_fwd_dest = m_load ? '0 : m_dest;

	assign load_use = e_load && e_dest != '0 &&
		((reads_rs(d_instr) && d_rs == e_dest) || (reads_rt(d_instr) && d_rt == e_dest));

	// The branch compares in decode, so it waits for anything in execute and for a load in memory.
	assign branch_stall = d_beq && (
		(e_dest != '0 && (d_rs == e_dest || d_rt == e_dest)) ||
		(m_load && m_dest != '0 && (d_rs == m_dest || d_rt == m_dest)));

	assign stall        = load_use || branch_stall;
	assign pc_enable    = !stall;
	assign if_id_enable = !stall;
	assign id_ex_flush  = stall;

	always_comb begin
		case (d_instr[31:26])
			`OP_BEQ: npc_mode = `NPC_BRANCH;
			`OP_J:   npc_mode = `NPC_JUMP;
			default: npc_mode = `NPC_SEQ;
		endcase
	end

	// Decode gets write-back results from the register file bypass.
	always_comb begin
		fwd.d1 = pick(d_rs, m_fwd_dest, '0);
		fwd.d2 = pick(d_rt, m_fwd_dest, '0);
		fwd.e1 = pick(e_rs, m_fwd_dest, w_dest);
		fwd.e2 = pick(e_rt, m_fwd_dest, w_dest);
		fwd.m  = pick(m_rt, '0, w_dest);
	end

	always_comb begin
		ex_ctrl = '{alu_op: alu_add, use_imm: 1'b0, zero_ext: 1'b0};
		if (is_rtype(e_instr)) begin
			case (e_instr[5:0])
				`FN_SUBU: ex_ctrl.alu_op = alu_sub;
				`FN_AND:  ex_ctrl.alu_op = alu_and;
				`FN_OR:   ex_ctrl.alu_op = alu_or;
				`FN_SLT:  ex_ctrl.alu_op = alu_slt;
				default:  ex_ctrl.alu_op = alu_add;
			endcase
		end else begin
			case (e_instr[31:26])
				`OP_ORI:        ex_ctrl = '{alu_op: alu_or, use_imm: 1'b1, zero_ext: 1'b1};
				`OP_LUI:        ex_ctrl = '{alu_op: alu_lui, use_imm: 1'b1, zero_ext: 1'b0};
				`OP_LW, `OP_SW: ex_ctrl.use_imm = 1'b1;
				default:        ex_ctrl.use_imm = 1'b0;
			endcase
		end
	end

	always_comb begin
		mem_ctrl.mem_read  = m_load;
		mem_ctrl.mem_write = m_instr[31:26] == `OP_SW;
	end

	always_comb begin
		wb_ctrl.reg_write = w_dest != '0;
		wb_ctrl.dest      = w_dest;
		wb_ctrl.wb_sel    = (w_instr[31:26] == `OP_LW) ? wb_mem : wb_alu;
	end

endmodule

`default_nettype wire

//--- rtl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_slt,
		alu_lui
	} alu_op_t;

	// Source of an operand: the value read in its own stage, or a younger result.
	typedef enum logic [1:0] {
		fwd_orig,
		fwd_mem,
		fwd_wb
	} fwd_sel_t;

	typedef enum logic {
		wb_alu,
		wb_mem
	} wb_sel_t;

	typedef struct packed {
		word_t pc;
		word_t instr;
	} if_id_t;

	typedef struct packed {
		word_t pc;
		word_t instr;
		word_t rs_val;
		word_t rt_val;
	} id_ex_t;

	typedef struct packed {
		word_t instr;
		word_t alu_result;
		word_t store_data;
	} ex_mem_t;

	typedef struct packed {
		word_t instr;
		word_t alu_result;
		word_t load_data;
	} mem_wb_t;

	typedef struct packed {
		alu_op_t alu_op;
		logic    use_imm;
		logic    zero_ext;
	} ex_ctrl_t;

	typedef struct packed {
		logic mem_read;
		logic mem_write;
	} mem_ctrl_t;

	typedef struct packed {
		logic      reg_write;
		reg_addr_t dest;
		wb_sel_t   wb_sel;
	} wb_ctrl_t;

	typedef struct packed {
		fwd_sel_t d1;
		fwd_sel_t d2;
		fwd_sel_t e1;
		fwd_sel_t e2;
		fwd_sel_t m;
	} fwd_ctrl_t;

	typedef struct packed {
		logic      valid;
		reg_addr_t dest;
		word_t     data;
	} wb_trace_t;

endpackage

`default_nettype wire

//--- rtl/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

`define CPU_RESET_PC 32'h0000_0000
`define CPU_NUM_REGS 32

`define OP_SPECIAL 6'b000000
`define OP_J       6'b000010
`define OP_BEQ     6'b000100
`define OP_ORI     6'b001101
`define OP_LUI     6'b001111
`define OP_LW      6'b100011
`define OP_SW      6'b101011

`define FN_ADDU 6'b100001
`define FN_SUBU 6'b100011
`define FN_AND  6'b100100
`define FN_OR   6'b100101
`define FN_SLT  6'b101010

// Next-PC source chosen by the instruction in decode.
`define NPC_SEQ    2'd0
`define NPC_BRANCH 2'd1
`define NPC_JUMP   2'd2

`endif
